/* common/uart_pkg.sv */
// uart register map, status field positions and payload types shared by the design.
package uart_pkg;

  localparam int AXI_ADDR_W = 4;
  localparam int AXI_DATA_W = 32;

  // word index taken from address bits 3:2.
  typedef logic [1:0] reg_addr_t;

  localparam reg_addr_t REG_SETUP = 2'd0;
  localparam reg_addr_t REG_FIFO  = 2'd1;
  localparam reg_addr_t REG_RXREG = 2'd2;
  localparam reg_addr_t REG_TXREG = 2'd3;

  typedef logic [7:0] uart_byte_t;

  // one received byte with its framing status.
  typedef struct packed {
    logic       ferr;
    uart_byte_t data;
  } rx_word_t;

  typedef logic [23:0] baud_div_t; // clocks per baud.

  // status and control field positions.
  localparam int RX_EMPTY_BIT = 8;
  localparam int RX_OVFL_BIT  = 9;
  localparam int RX_FERR_BIT  = 10;
  localparam int TX_BUSY_BIT  = 8;
  localparam int TX_FULL_BIT  = 11;
  localparam int RESET_BIT    = 12; // same position in rxreg and txreg.
  localparam int FLOW_OFF_BIT = 30; // in setup.

  // rts goes high once the receive fill passes depth minus this.
  localparam int RTS_MARGIN = 3;

endpackage

/* uart/uart_tx.sv */
// 8n1 serial transmitter with a programmable baud counter and cts hold-off.
`timescale 1ns/1ps
module uart_tx (
  input  logic                 S_AXI_ACLK,
  input  logic                 S_AXI_ARESETN,
  input  logic                 i_reset,
  input  uart_pkg::baud_div_t  i_baud_div,
  input  logic                 i_cts_n,
  input  logic                 i_valid,
  input  uart_pkg::uart_byte_t i_data,
  output logic                 o_busy,
  output logic                 o_uart_tx
);

  logic                r_busy;
  logic                take;
  logic                bit_end;
  logic [3:0]          bit_cnt;
  logic [8:0]          shift;
  uart_pkg::baud_div_t baud_cnt;

  // a paused peer counts as busy, so no byte is taken.
  assign o_busy  = r_busy || i_cts_n;
  assign take    = i_valid && !o_busy;
  assign bit_end = r_busy && (baud_cnt == '0);

  always_ff @(posedge S_AXI_ACLK) begin
    if (!S_AXI_ARESETN || i_reset) begin
      r_busy    <= 1'b0;
      o_uart_tx <= 1'b1;
      baud_cnt  <= '0;
      bit_cnt   <= '0;
    end else if (take) begin
      r_busy    <= 1'b1;
      o_uart_tx <= 1'b0; // start bit.
      baud_cnt  <= i_baud_div - 1'b1;
      bit_cnt   <= '0;
    end else if (r_busy) begin
      if (!bit_end) begin
        baud_cnt <= baud_cnt - 1'b1;
      end else if (bit_cnt == 4'd9) begin
        r_busy <= 1'b0; // stop bit done.
      end else begin
        o_uart_tx <= shift[0];
        baud_cnt  <= i_baud_div - 1'b1;
        bit_cnt   <= bit_cnt + 1'b1;
      end
    end
  end

  // data lsb first, stop bit parked on top.
  always_ff @(posedge S_AXI_ACLK) begin
    if (take) shift <= {1'b1, i_data};
    else if (bit_end) shift <= {1'b1, shift[8:1]};
  end

endmodule

/* uart/uart_rx.sv */
// 8n1 serial receiver with mid-bit sampling and stop-bit frame check.
`timescale 1ns/1ps
module uart_rx (
  input  logic                S_AXI_ACLK,
  input  logic                S_AXI_ARESETN,
  input  logic                i_reset,
  input  uart_pkg::baud_div_t i_baud_div,
  input  logic                i_uart_rx,
  output logic                o_stb,
  output uart_pkg::rx_word_t  o_word
);

  logic [1:0]           rx_sync;
  logic                 rx_last;
  logic                 line;
  logic                 busy;
  logic                 sample;
  logic [3:0]           bit_cnt;
  uart_pkg::uart_byte_t shift;
  uart_pkg::baud_div_t  baud_cnt;

  assign line   = rx_sync[1];
  assign sample = busy && (baud_cnt == '0);

  always_ff @(posedge S_AXI_ACLK) begin
    if (!S_AXI_ARESETN) begin
      rx_sync <= 2'b11; // line idles high.
      rx_last <= 1'b1;
    end else begin
      rx_sync <= {rx_sync[0], i_uart_rx};
      rx_last <= line;
    end
  end

  always_ff @(posedge S_AXI_ACLK) begin
    if (!S_AXI_ARESETN || i_reset) begin
      busy     <= 1'b0;
      o_stb    <= 1'b0;
      baud_cnt <= '0;
      bit_cnt  <= '0;
    end else begin
      o_stb <= 1'b0;
      if (!busy) begin
        if (rx_last && !line) begin
          busy     <= 1'b1;
          baud_cnt <= (i_baud_div >> 1) - 1'b1; // land in the middle of the start bit.
          bit_cnt  <= '0;
        end
      end else if (!sample) begin
        baud_cnt <= baud_cnt - 1'b1;
      end else begin
        baud_cnt <= i_baud_div - 1'b1;
        bit_cnt  <= bit_cnt + 1'b1;
        if (bit_cnt == 4'd0 && line) begin
          busy <= 1'b0; // glitch, not a start bit.
        end else if (bit_cnt == 4'd9) begin
          busy  <= 1'b0;
          o_stb <= 1'b1;
        end
      end
    end
  end

  always_ff @(posedge S_AXI_ACLK) begin
    if (sample && bit_cnt != 4'd0 && bit_cnt != 4'd9) shift <= {line, shift[7:1]};
    if (sample && bit_cnt == 4'd9) begin
      o_word.data <= shift;
      o_word.ferr <= !line; // low stop bit.
    end
  end

endmodule

/* verilog/uart_fifo.sv */
// synchronous first-word fall-through fifo with a fill count, for any payload type.
`timescale 1ns/1ps
module uart_fifo #(
  parameter int  LGFLEN    = 4,
  parameter type payload_t = logic [7:0]
) (
  input  logic            S_AXI_ACLK,
  input  logic            S_AXI_ARESETN,
  input  logic            i_flush,
  input  logic            i_push,
  input  payload_t        i_data,
  input  logic            i_pop,
  output payload_t        o_head,
  output logic            o_empty_n,
  output logic [LGFLEN:0] o_fill,
  output logic            o_overflow
);

  localparam int DEPTH = 1 << LGFLEN;

  payload_t        mem [DEPTH];
  logic [LGFLEN:0] wr_ptr;
  logic [LGFLEN:0] rd_ptr;
  logic            full;
  logic            do_push;
  logic            do_pop;

  // pointers carry one extra bit so full and empty differ.
  assign o_fill    = wr_ptr - rd_ptr;
  assign full      = o_fill[LGFLEN];
  assign o_empty_n = (wr_ptr != rd_ptr);
  assign do_push   = i_push && !full;
  assign do_pop    = i_pop && o_empty_n;

  always_ff @(posedge S_AXI_ACLK) begin
    if (!S_AXI_ARESETN || i_flush) begin
      wr_ptr     <= '0;
      rd_ptr     <= '0;
      o_overflow <= 1'b0;
    end else begin
      if (do_push) wr_ptr <= wr_ptr + 1'b1;
      if (do_pop) rd_ptr <= rd_ptr + 1'b1;
      o_overflow <= i_push && full; // dropped byte.
    end
  end

  always_ff @(posedge S_AXI_ACLK) begin
    if (do_push) mem[wr_ptr[LGFLEN-1:0]] <= i_data;
  end

  assign o_head = mem[rd_ptr[LGFLEN-1:0]];

endmodule

/* verilog/axil_uart_regs.sv */
// axi-lite control block for the uart: bus handshakes, setup, status words and fifo strobes.
`timescale 1ns/1ps
module axil_uart_regs #(
  parameter uart_pkg::baud_div_t INITIAL_BAUD = 24'd25,
  parameter int LGFLEN = 4
) (
  input  logic                            S_AXI_ACLK,
  input  logic                            S_AXI_ARESETN,
  input  logic                            i_awvalid,
  output logic                            o_awready,
  input  logic [uart_pkg::AXI_ADDR_W-1:0] i_awaddr,
  input  logic                            i_wvalid,
  output logic                            o_wready,
  input  logic [uart_pkg::AXI_DATA_W-1:0] i_wdata,
  input  logic [3:0]                      i_wstrb,
  output logic                            o_bvalid,
  input  logic                            i_bready,
  output logic [1:0]                      o_bresp,
  input  logic                            i_arvalid,
  output logic                            o_arready,
  input  logic [uart_pkg::AXI_ADDR_W-1:0] i_araddr,
  output logic                            o_rvalid,
  input  logic                            i_rready,
  output logic [uart_pkg::AXI_DATA_W-1:0] o_rdata,
  output logic [1:0]                      o_rresp,
  output logic                            o_txf_push,
  output uart_pkg::uart_byte_t            o_txf_data,
  output logic                            o_txf_reset,
  input  logic [LGFLEN:0]                 i_txf_fill,
  input  logic                            i_tx_busy,
  output logic                            o_rxf_pop,
  output logic                            o_rxf_reset,
  input  uart_pkg::rx_word_t              i_rxf_head,
  input  logic [LGFLEN:0]                 i_rxf_fill,
  input  logic                            i_rxf_overflow,
  output logic                            o_uart_reset,
  output uart_pkg::baud_div_t             o_baud_div,
  input  logic                            i_cts_n,
  output logic                            o_cts_gated,
  output logic                            o_rts_n,
  output logic                            o_uart_rx_int,
  output logic                            o_uart_tx_int
);

  localparam int DEPTH = 1 << LGFLEN;
  localparam logic [LGFLEN:0] RTS_LEVEL = (LGFLEN + 1)'(DEPTH - uart_pkg::RTS_MARGIN);
  localparam logic [LGFLEN:0] FULL_LEVEL = (LGFLEN + 1)'(DEPTH);

  logic                            wr_en;
  logic                            wr_setup_all;
  logic                            rd_hs;
  logic                            rd_pending;
  logic                            rx_ovfl;
  logic                            tx_armed;
  logic                            flow_off;
  uart_pkg::reg_addr_t             waddr;
  uart_pkg::reg_addr_t             rd_addr;
  logic [uart_pkg::AXI_DATA_W-1:0] setup;
  logic [uart_pkg::AXI_DATA_W-1:0] new_setup;
  logic [uart_pkg::AXI_DATA_W-1:0] rx_word;
  logic [uart_pkg::AXI_DATA_W-1:0] tx_word;
  logic [uart_pkg::AXI_DATA_W-1:0] fifo_word;

  // write channel, one beat at a time.
  assign waddr = i_awaddr[3:2];
  assign wr_en = o_awready;

  always_ff @(posedge S_AXI_ACLK) begin
    if (!S_AXI_ARESETN) begin
      o_awready <= 1'b0;
      o_bvalid  <= 1'b0;
    end else begin
      o_awready <= !o_awready && i_awvalid && i_wvalid && (!o_bvalid || i_bready);
      if (wr_en) o_bvalid <= 1'b1;
      else if (i_bready) o_bvalid <= 1'b0;
    end
  end

  assign o_wready = o_awready;
  assign o_bresp  = 2'b00;

  always_comb begin
    new_setup = setup;
    for (int k = 0; k < 4; k++) begin
      if (i_wstrb[k]) new_setup[k*8+:8] = i_wdata[k*8+:8];
    end
  end

  always_ff @(posedge S_AXI_ACLK) begin
    if (!S_AXI_ARESETN) setup <= {8'h00, INITIAL_BAUD}; // flow control enabled.
    else if (wr_en && waddr == uart_pkg::REG_SETUP) setup <= new_setup;
  end

  assign wr_setup_all = wr_en && waddr == uart_pkg::REG_SETUP && (&i_wstrb);

  always_ff @(posedge S_AXI_ACLK) begin
    if (!S_AXI_ARESETN) begin
      o_uart_reset <= 1'b0;
      o_txf_reset  <= 1'b0;
      o_rxf_reset  <= 1'b0;
      o_txf_push   <= 1'b0;
    end else begin
      o_uart_reset <= wr_setup_all;
      o_txf_reset  <= wr_setup_all || (wr_en && waddr == uart_pkg::REG_TXREG && i_wstrb[1]
                      && i_wdata[uart_pkg::RESET_BIT]);
      o_rxf_reset  <= wr_setup_all || (wr_en && waddr == uart_pkg::REG_RXREG && i_wstrb[1]
                      && i_wdata[uart_pkg::RESET_BIT]);
      o_txf_push   <= wr_en && waddr == uart_pkg::REG_TXREG && i_wstrb[0];
    end
  end

  always_ff @(posedge S_AXI_ACLK) begin
    if (wr_en) o_txf_data <= i_wdata[7:0];
  end

  // sticky until written back as one.
  always_ff @(posedge S_AXI_ACLK) begin
    if (!S_AXI_ARESETN || o_rxf_reset) rx_ovfl <= 1'b0;
    else if (wr_en && waddr == uart_pkg::REG_RXREG && i_wstrb[1]
             && i_wdata[uart_pkg::RX_OVFL_BIT]) rx_ovfl <= 1'b0;
    else if (i_rxf_overflow) rx_ovfl <= 1'b1;
  end

  // the tx interrupt only reports idle once something was queued.
  always_ff @(posedge S_AXI_ACLK) begin
    if (!S_AXI_ARESETN || o_txf_reset) tx_armed <= 1'b0;
    else if (o_txf_push) tx_armed <= 1'b1;
  end

  assign flow_off    = setup[uart_pkg::FLOW_OFF_BIT];
  assign o_cts_gated = i_cts_n && !flow_off;
  assign o_baud_div  = setup[23:0];

  always_ff @(posedge S_AXI_ACLK) begin
    if (!S_AXI_ARESETN) o_rts_n <= 1'b0;
    else o_rts_n <= !flow_off && (i_rxf_fill > RTS_LEVEL); // ask the peer to pause.
  end

  assign o_uart_rx_int = (i_rxf_fill != '0);
  assign o_uart_tx_int = tx_armed && (i_txf_fill == '0) && !i_tx_busy;

  // read words.
  assign fifo_word = {16'(i_txf_fill), 16'(i_rxf_fill)};

  always_comb begin
    rx_word = '0;
    rx_word[7:0] = i_rxf_head.data;
    rx_word[uart_pkg::RX_EMPTY_BIT] = (i_rxf_fill == '0);
    rx_word[uart_pkg::RX_OVFL_BIT] = rx_ovfl;
    rx_word[uart_pkg::RX_FERR_BIT] = i_rxf_head.ferr;
    tx_word = '0;
    tx_word[uart_pkg::TX_BUSY_BIT] = i_tx_busy || (i_txf_fill != '0);
    tx_word[uart_pkg::TX_FULL_BIT] = (i_txf_fill == FULL_LEVEL);
  end

  // read channel, one read in flight.
  assign rd_hs = i_arvalid && o_arready;

  always_ff @(posedge S_AXI_ACLK) begin
    if (!S_AXI_ARESETN) begin
      o_arready  <= 1'b1;
      rd_pending <= 1'b0;
      o_rvalid   <= 1'b0;
      o_rxf_pop  <= 1'b0;
    end else begin
      if (rd_hs) o_arready <= 1'b0;
      else if (o_rvalid && i_rready) o_arready <= 1'b1;
      rd_pending <= rd_hs;
      if (rd_pending) o_rvalid <= 1'b1;
      else if (i_rready) o_rvalid <= 1'b0;
      o_rxf_pop <= rd_hs && i_araddr[3:2] == uart_pkg::REG_RXREG; // head is captured first.
    end
  end

  always_ff @(posedge S_AXI_ACLK) begin
    if (rd_hs) rd_addr <= i_araddr[3:2];
    if (rd_pending) begin
      case (rd_addr)
        uart_pkg::REG_SETUP: o_rdata <= setup;
        uart_pkg::REG_FIFO:  o_rdata <= fifo_word;
        uart_pkg::REG_RXREG: o_rdata <= rx_word;
        default:             o_rdata <= tx_word;
      endcase
    end
  end

  assign o_rresp = 2'b00;

endmodule

/* verilog/axil_uart.sv */
// axi-lite uart top: register block, transmit and receive fifos, serializer and deserializer.
`timescale 1ns/1ps
module axil_uart #(
  parameter uart_pkg::baud_div_t INITIAL_BAUD = 24'd25,
  parameter int LGFLEN = 4
) (
  input  logic                            S_AXI_ACLK,
  input  logic                            S_AXI_ARESETN,
  input  logic                            i_awvalid,
  output logic                            o_awready,
  input  logic [uart_pkg::AXI_ADDR_W-1:0] i_awaddr,
  input  logic                            i_wvalid,
  output logic                            o_wready,
  input  logic [uart_pkg::AXI_DATA_W-1:0] i_wdata,
  input  logic [3:0]                      i_wstrb,
  output logic                            o_bvalid,
  input  logic                            i_bready,
  output logic [1:0]                      o_bresp,
  input  logic                            i_arvalid,
  output logic                            o_arready,
  input  logic [uart_pkg::AXI_ADDR_W-1:0] i_araddr,
  output logic                            o_rvalid,
  input  logic                            i_rready,
  output logic [uart_pkg::AXI_DATA_W-1:0] o_rdata,
  output logic [1:0]                      o_rresp,
  input  logic                            i_uart_rx,
  output logic                            o_uart_tx,
  input  logic                            i_cts_n,
  output logic                            o_rts_n,
  output logic                            o_uart_rx_int,
  output logic                            o_uart_tx_int
);

  logic                 txf_push, txf_reset, txf_empty_n, tx_busy, tx_take;
  logic                 rxf_pop, rxf_reset, rxf_overflow, rx_stb;
  logic                 uart_reset, cts_gated;
  logic [LGFLEN:0]      txf_fill, rxf_fill;
  uart_pkg::uart_byte_t txf_data, tx_data;
  uart_pkg::rx_word_t   rxf_head, rx_word;
  uart_pkg::baud_div_t  baud_div;

  assign tx_take = txf_empty_n && !tx_busy; // pop and take are one event.

  axil_uart_regs #(.INITIAL_BAUD(INITIAL_BAUD), .LGFLEN(LGFLEN)) u_regs (
    .S_AXI_ACLK, .S_AXI_ARESETN,
    .i_awvalid, .o_awready, .i_awaddr, .i_wvalid, .o_wready, .i_wdata, .i_wstrb,
    .o_bvalid, .i_bready, .o_bresp,
    .i_arvalid, .o_arready, .i_araddr, .o_rvalid, .i_rready, .o_rdata, .o_rresp,
    .o_txf_push(txf_push), .o_txf_data(txf_data), .o_txf_reset(txf_reset),
    .i_txf_fill(txf_fill), .i_tx_busy(tx_busy),
    .o_rxf_pop(rxf_pop), .o_rxf_reset(rxf_reset), .i_rxf_head(rxf_head),
    .i_rxf_fill(rxf_fill), .i_rxf_overflow(rxf_overflow),
    .o_uart_reset(uart_reset), .o_baud_div(baud_div),
    .i_cts_n, .o_cts_gated(cts_gated), .o_rts_n, .o_uart_rx_int, .o_uart_tx_int
  );

  uart_fifo #(.LGFLEN(LGFLEN), .payload_t(uart_pkg::uart_byte_t)) u_txfifo (
    .S_AXI_ACLK, .S_AXI_ARESETN, .i_flush(txf_reset),
    .i_push(txf_push), .i_data(txf_data), .i_pop(tx_take),
    .o_head(tx_data), .o_empty_n(txf_empty_n), .o_fill(txf_fill), .o_overflow()
  );

  uart_fifo #(.LGFLEN(LGFLEN), .payload_t(uart_pkg::rx_word_t)) u_rxfifo (
    .S_AXI_ACLK, .S_AXI_ARESETN, .i_flush(rxf_reset),
    .i_push(rx_stb), .i_data(rx_word), .i_pop(rxf_pop),
    .o_head(rxf_head), .o_empty_n(), .o_fill(rxf_fill), .o_overflow(rxf_overflow)
  );

  uart_tx u_tx (
    .S_AXI_ACLK, .S_AXI_ARESETN, .i_reset(uart_reset), .i_baud_div(baud_div),
    .i_cts_n(cts_gated), .i_valid(txf_empty_n), .i_data(tx_data),
    .o_busy(tx_busy), .o_uart_tx
  );

  uart_rx u_rx (
    .S_AXI_ACLK, .S_AXI_ARESETN, .i_reset(uart_reset), .i_baud_div(baud_div),
    .i_uart_rx, .o_stb(rx_stb), .o_word(rx_word)
  );

endmodule

/* dv/axil_uart_tb.sv */
// testbench for the axi-lite uart: bus tasks, 8n1 line models and directed tests.
`timescale 1ns/1ps
module axil_uart_tb;

  localparam int INITIAL_BAUD = 25;
  localparam int LGFLEN       = 4;
  localparam int DEPTH        = 1 << LGFLEN;
  localparam int BAUD         = 16; // divisor for all serial traffic.
  localparam int BUS_LIMIT    = 50;
  localparam int LINE_LIMIT   = 40 * BAUD;

  logic        S_AXI_ACLK = 1'b0;
  logic        S_AXI_ARESETN;
  logic        i_awvalid;
  logic        i_wvalid;
  logic        i_bready;
  logic        i_arvalid;
  logic        i_rready;
  logic [3:0]  i_awaddr;
  logic [3:0]  i_araddr;
  logic [3:0]  i_wstrb;
  logic [31:0] i_wdata;
  logic        o_awready;
  logic        o_wready;
  logic        o_bvalid;
  logic        o_arready;
  logic        o_rvalid;
  logic [1:0]  o_bresp;
  logic [1:0]  o_rresp;
  logic [31:0] o_rdata;
  logic        i_uart_rx;
  logic        i_cts_n;
  logic        o_uart_tx;
  logic        o_rts_n;
  logic        o_uart_rx_int;
  logic        o_uart_tx_int;

  axil_uart #(.INITIAL_BAUD(24'(INITIAL_BAUD)), .LGFLEN(LGFLEN)) dut (.*);

  always #10 S_AXI_ACLK = ~S_AXI_ACLK;

  function automatic logic [3:0] reg_addr(input uart_pkg::reg_addr_t idx);
    return {idx, 2'b00};
  endfunction

  task automatic fail_run(input string why);
    $display("%s", why);
    $display("CHECKS FAILED");
    $fatal(1, "simulation stopped");
  endtask

  task automatic check_eq(input string what, input logic [31:0] got, input logic [31:0] exp);
    assert (got === exp)
    else fail_run($sformatf("** Error at %0d ns: %s is %h, expected %h", $time, what, got, exp));
  endtask

  task automatic axil_write(input logic [3:0] addr, input logic [31:0] data,
                            input logic [3:0] strb);
    int n;
    @(posedge S_AXI_ACLK);
    i_awvalid <= 1'b1;
    i_wvalid  <= 1'b1;
    i_awaddr  <= addr;
    i_wdata   <= data;
    i_wstrb   <= strb;
    i_bready  <= 1'b1;
    n = 0;
    do begin
      @(negedge S_AXI_ACLK);
      n++;
    end while (!o_awready && n < BUS_LIMIT);
    assert (o_awready) else fail_run("write address and data were never accepted");
    check_eq("wready with awready", 32'(o_wready), 32'd1);
    @(posedge S_AXI_ACLK);
    i_awvalid <= 1'b0;
    i_wvalid  <= 1'b0;
    n = 0;
    do begin
      @(negedge S_AXI_ACLK);
      n++;
    end while (!o_bvalid && n < BUS_LIMIT);
    assert (o_bvalid) else fail_run("write response never arrived");
    check_eq("wready after the accept", 32'(o_wready), 32'd0);
    check_eq("write response", 32'(o_bresp), 32'd0);
    @(posedge S_AXI_ACLK);
    i_bready <= 1'b0;
  endtask

  task automatic axil_read(input logic [3:0] addr, output logic [31:0] data);
    int n;
    @(posedge S_AXI_ACLK);
    i_arvalid <= 1'b1;
    i_araddr  <= addr;
    i_rready  <= 1'b1;
    n = 0;
    do begin
      @(negedge S_AXI_ACLK);
      n++;
    end while (o_arready && n < BUS_LIMIT);
    assert (!o_arready) else fail_run("read address was never accepted");
    @(posedge S_AXI_ACLK);
    i_arvalid <= 1'b0;
    n = 0;
    do begin
      @(negedge S_AXI_ACLK);
      n++;
    end while (!o_rvalid && n < BUS_LIMIT);
    assert (o_rvalid) else fail_run("read data never arrived");
    check_eq("read response", 32'(o_rresp), 32'd0);
    data = o_rdata;
    @(posedge S_AXI_ACLK);
    i_rready <= 1'b0;
  endtask

  // drives one 8n1 frame, then two idle bit times.
  task automatic send_serial(input logic [7:0] data, input logic stop_bit);
    logic [9:0] frame;
    frame = {stop_bit, data, 1'b0};
    for (int i = 0; i < 10; i++) begin
      @(posedge S_AXI_ACLK);
      i_uart_rx <= frame[i];
      repeat (BAUD - 1) @(posedge S_AXI_ACLK);
    end
    @(posedge S_AXI_ACLK);
    i_uart_rx <= 1'b1;
    repeat (2 * BAUD) @(posedge S_AXI_ACLK);
  endtask

  // samples each bit of one frame in its middle.
  task automatic recv_serial(output logic [7:0] data, output logic stop);
    int n;
    n = 0;
    do begin
      @(negedge S_AXI_ACLK);
      n++;
    end while (o_uart_tx && n < LINE_LIMIT);
    assert (!o_uart_tx) else fail_run("no start bit appeared on the transmit line");
    repeat (BAUD / 2) @(negedge S_AXI_ACLK);
    assert (!o_uart_tx) else fail_run("start bit on the transmit line was too short");
    for (int i = 0; i < 8; i++) begin
      repeat (BAUD) @(negedge S_AXI_ACLK);
      data[i] = o_uart_tx;
    end
    repeat (BAUD) @(negedge S_AXI_ACLK);
    stop = o_uart_tx;
  endtask

  task automatic reset_values();
    logic [31:0] rd;
    @(negedge S_AXI_ACLK);
    check_eq("handshake outputs after reset",
             {27'd0, o_awready, o_wready, o_bvalid, o_arready, o_rvalid}, 32'b00010);
    check_eq("transmit line after reset", 32'(o_uart_tx), 32'd1);
    axil_read(reg_addr(uart_pkg::REG_SETUP), rd);
    check_eq("SETUP after reset", rd, 32'(INITIAL_BAUD));
    axil_read(reg_addr(uart_pkg::REG_FIFO), rd);
    check_eq("FIFO after reset", rd, 32'd0);
    axil_read(reg_addr(uart_pkg::REG_RXREG), rd);
    check_eq("RXREG empty bit after reset", 32'(rd[uart_pkg::RX_EMPTY_BIT]), 32'd1);
    @(negedge S_AXI_ACLK);
    check_eq("rts after reset", 32'(o_rts_n), 32'd0);
    check_eq("interrupts after reset", {30'd0, o_uart_rx_int, o_uart_tx_int}, 32'd0);
  endtask

  task automatic setup_strobes();
    logic [31:0] rd;
    axil_write(reg_addr(uart_pkg::REG_SETUP), 32'd8, 4'hf);
    axil_read(reg_addr(uart_pkg::REG_SETUP), rd);
    check_eq("SETUP full write", rd, 32'd8);
    axil_write(reg_addr(uart_pkg::REG_SETUP), 32'haabb_00cc, 4'b0110);
    axil_read(reg_addr(uart_pkg::REG_SETUP), rd);
    check_eq("SETUP partial write", rd, 32'h00bb_0008); // lanes 1 and 2 replaced.
    axil_write(reg_addr(uart_pkg::REG_SETUP), 32'(BAUD), 4'hf);
    axil_read(reg_addr(uart_pkg::REG_SETUP), rd);
    check_eq("SETUP working divisor", rd, 32'(BAUD));
  endtask

  task automatic transmit_bytes();
    logic [7:0] sent [3];
    logic [7:0] got;
    logic       stop;
    int         n;
    for (int i = 0; i < 3; i++) sent[i] = 8'($urandom);
    fork
      for (int i = 0; i < 3; i++) begin
        axil_write(reg_addr(uart_pkg::REG_TXREG), {24'd0, sent[i]}, 4'b0001);
      end
      for (int j = 0; j < 3; j++) begin
        recv_serial(got, stop);
        check_eq($sformatf("transmitted byte %0d", j), 32'(got), 32'(sent[j]));
        check_eq($sformatf("stop bit of byte %0d", j), 32'(stop), 32'd1);
      end
    join
    n = 0;
    do begin
      @(negedge S_AXI_ACLK);
      n++;
    end while (!o_uart_tx_int && n < LINE_LIMIT);
    assert (o_uart_tx_int) else fail_run("transmit interrupt did not rise after the last byte");
  endtask

  task automatic receive_bytes();
    logic [31:0] rd;
    send_serial(8'ha5, 1'b1);
    send_serial(8'h3c, 1'b0); // broken stop bit.
    @(negedge S_AXI_ACLK);
    check_eq("receive interrupt", 32'(o_uart_rx_int), 32'd1);
    axil_read(reg_addr(uart_pkg::REG_RXREG), rd);
    check_eq("first received byte", 32'(rd[7:0]), 32'ha5);
    check_eq("frame error of first byte", 32'(rd[uart_pkg::RX_FERR_BIT]), 32'd0);
    check_eq("empty bit with data", 32'(rd[uart_pkg::RX_EMPTY_BIT]), 32'd0);
    axil_read(reg_addr(uart_pkg::REG_RXREG), rd);
    check_eq("second received byte", 32'(rd[7:0]), 32'h3c);
    check_eq("frame error of second byte", 32'(rd[uart_pkg::RX_FERR_BIT]), 32'd1);
    axil_read(reg_addr(uart_pkg::REG_RXREG), rd);
    check_eq("empty bit after draining", 32'(rd[uart_pkg::RX_EMPTY_BIT]), 32'd1);
  endtask

  task automatic flow_and_overflow();
    logic [31:0] rd;
    logic [7:0]  got;
    logic        stop;
    @(posedge S_AXI_ACLK);
    i_cts_n <= 1'b1;
    axil_write(reg_addr(uart_pkg::REG_TXREG), 32'h0000_0055, 4'b0001);
    repeat (20 * BAUD) begin
      @(negedge S_AXI_ACLK);
      assert (o_uart_tx)
      else fail_run($sformatf("** Error at %0d ns: frame started while CTS was high", $time));
    end
    axil_read(reg_addr(uart_pkg::REG_TXREG), rd);
    check_eq("busy bit while held", 32'(rd[uart_pkg::TX_BUSY_BIT]), 32'd1);
    @(posedge S_AXI_ACLK);
    i_cts_n <= 1'b0;
    recv_serial(got, stop);
    check_eq("byte released by CTS", 32'(got), 32'h55);
    check_eq("stop bit of released byte", 32'(stop), 32'd1);
    for (int i = 0; i < DEPTH - uart_pkg::RTS_MARGIN; i++) send_serial(8'(8'h30 + i), 1'b1);
    @(negedge S_AXI_ACLK);
    check_eq("rts at the threshold", 32'(o_rts_n), 32'd0);
    send_serial(8'(8'h30 + DEPTH - uart_pkg::RTS_MARGIN), 1'b1);
    @(negedge S_AXI_ACLK);
    check_eq("rts above the threshold", 32'(o_rts_n), 32'd1);
    for (int i = DEPTH - uart_pkg::RTS_MARGIN + 1; i <= DEPTH; i++) begin
      send_serial(8'(8'h30 + i), 1'b1); // the last one has no room.
    end
    axil_read(reg_addr(uart_pkg::REG_RXREG), rd);
    check_eq("oldest byte after overflow", 32'(rd[7:0]), 32'h30);
    check_eq("overflow bit", 32'(rd[uart_pkg::RX_OVFL_BIT]), 32'd1);
    axil_write(reg_addr(uart_pkg::REG_RXREG), 32'd1 << uart_pkg::RX_OVFL_BIT, 4'b0010);
    axil_read(reg_addr(uart_pkg::REG_RXREG), rd);
    check_eq("next byte after clear", 32'(rd[7:0]), 32'h31);
    check_eq("overflow bit after clear", 32'(rd[uart_pkg::RX_OVFL_BIT]), 32'd0);
  endtask

  task automatic rx_path_reset();
    logic [31:0] rd;
    axil_read(reg_addr(uart_pkg::REG_FIFO), rd);
    check_eq("receive fill before reset", 32'(rd[15:0]), 32'(DEPTH - 2));
    axil_write(reg_addr(uart_pkg::REG_RXREG), 32'd1 << uart_pkg::RESET_BIT, 4'b0010);
    axil_read(reg_addr(uart_pkg::REG_FIFO), rd);
    check_eq("receive fill after reset", 32'(rd[15:0]), 32'd0);
    axil_read(reg_addr(uart_pkg::REG_RXREG), rd);
    check_eq("empty bit after path reset", 32'(rd[uart_pkg::RX_EMPTY_BIT]), 32'd1);
    @(negedge S_AXI_ACLK);
    check_eq("rts after path reset", 32'(o_rts_n), 32'd0);
  endtask

  initial begin
    void'($urandom(50032));
    S_AXI_ARESETN <= 1'b0;
    i_awvalid     <= 1'b0;
    i_wvalid      <= 1'b0;
    i_bready      <= 1'b0;
    i_arvalid     <= 1'b0;
    i_rready      <= 1'b0;
    i_awaddr      <= '0;
    i_araddr      <= '0;
    i_wstrb       <= '0;
    i_wdata       <= '0;
    i_uart_rx     <= 1'b1; // idle line.
    i_cts_n       <= 1'b0;
    repeat (3) @(posedge S_AXI_ACLK);
    S_AXI_ARESETN <= 1'b1;
    reset_values();
    setup_strobes();
    transmit_bytes();
    receive_bytes();
    flow_and_overflow();
    rx_path_reset();
    $display("ALL CHECKS PASSED");
    $finish;
  end

endmodule

/* verilog.f */
common/uart_pkg.sv
uart/uart_tx.sv
uart/uart_rx.sv
verilog/uart_fifo.sv
verilog/axil_uart_regs.sv
verilog/axil_uart.sv
dv/axil_uart_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# compile the uart testbench with verilator and run it; the exit status is the result.
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert \
  --top-module axil_uart_tb \
  -f verilog.f \
  -o sim_axil_uart

./obj_dir/sim_axil_uart
